// File: sim/cpuCore_vectors.txt
// kind a b c: kind 1 is program word a, kind 2 is an expected write-back
// to register a with data b and flags c (hex of Z N C V)
1 0885 0 0   // ADDI r1, 5
2 1 0005 0
1 090F 0 0   // ADDI r2, 15
2 2 000F 0
1 0590 0 0   // ADD  r3, r1
2 3 0005 0
1 15A0 0 0   // SUB  r3, r2 with borrow
2 3 FFF6 4
1 0000 0 0   // NOP
1 05B0 0 0   // ADD  r3, r3 with carry out
2 3 FFEC 6
1 1082 0 0   // ADCI r1, 2 plus carry
2 1 0008 0
1 1510 0 0   // SUB  r2, r1 without borrow
2 2 0007 2
1 19A0 0 0   // AND  r3, r2 clears C
2 3 0004 0
1 0E20 0 0   // ADC  r4, r2 with carry clear
2 4 0007 0
1 1530 0 0   // SUB  r2, r3
2 2 0003 2
1 1E40 0 0   // XOR  r4, r4 gives zero
2 4 0000 8
1 0000 0 0   // NOP

// File: vlog.f
src/opcodes.sv
src/stageTypes.sv
src/handoff.sv
src/busFetch.sv
src/control.sv
src/execute.sv
src/cpuCore.sv
sim/cpuCore_asserts.sv
sim/cpuCore_tb.sv

// File: Makefile
TOP = cpuCore_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// File: sim/cpuCore_tb.sv
`timescale 1ns/1ps

module cpuCore_tb;

   localparam stageTypes::busPads_t idlePads =
      '{SysBusOut: '0, SysBusOe: 1'b0, ALE: 1'b0, nME: 1'b1, nOE: 1'b1};

   logic                   Clock;
   logic                   nReset;
   logic                   Rdy;
   logic [15:0]            SysBusIn;
   stageTypes::busPads_t   Pads;
   logic                   WbValid;
   stageTypes::writeBack_t Wb;

   logic [15:0]            vec [256];   // Four words per vector line
   logic [15:0]            mem [256];   // Program memory
   stageTypes::writeBack_t expQ [$];
   stageTypes::writeBack_t want;
   stageTypes::writeBack_t nextWb;
   int                     progLen;
   int                     cycles;
   int                     limit;
   int                     seed;
   logic [15:0]            busAddr;     // Address latched on ALE
   logic [15:0]            nextAddr;

   cpuCore #(.AddrWidth(8)) uut (
      .Clock(Clock), .nReset(nReset), .Rdy(Rdy), .SysBusIn(SysBusIn),
      .Pads(Pads), .WbValid(WbValid), .Wb(Wb)
   );

   task automatic abortRun();
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic checkWb(input stageTypes::writeBack_t got,
                          input stageTypes::writeBack_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: Wb got r%0d=%h flags %b, expected r%0d=%h flags %b",
                  $time, got.addr, got.data, got.flags, exp.addr, exp.data, exp.flags);
         abortRun();
      end
   endtask

   task automatic checkPads(input stageTypes::busPads_t got,
                            input stageTypes::busPads_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: Pads got %h, expected %h", $time, got, exp);
         abortRun();
      end
   endtask

   task automatic checkAddr(input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: SysBusOut at ALE got %h, expected %h", $time, got, exp);
         abortRun();
      end
   endtask

   initial begin
      Clock = 1'b0;
      forever #4 Clock = ~Clock;
   end

   // Memory model and write-back monitor driving inputs 1 ns after the edge
   always begin
      @(posedge Clock);
      #1;
      cycles++;
      if (cycles > limit) begin
         $display("Timeout after %0d cycles with %0d write-backs missing",
                  cycles, expQ.size());
         abortRun();
      end
      if (Pads.ALE) begin
         checkAddr(Pads.SysBusOut, nextAddr);   // One fetch per address
         busAddr  = Pads.SysBusOut;
         nextAddr = nextAddr + 16'd1;
      end
      SysBusIn = !Pads.nOE ? mem[busAddr[7:0]] : '0;
      Rdy      = 1'($random(seed));   // Random wait states
      if (WbValid) begin
         if (expQ.size() == 0) begin
            $display("Write-back seen after the last expected one at %0t ns", $time);
            abortRun();
         end else begin
            nextWb = expQ.pop_front();
            checkWb(Wb, nextWb);
         end
      end
   end

   initial begin
      nReset   = 1'b0;
      Rdy      = 1'b0;
      SysBusIn = '0;
      seed     = 30632;
      busAddr  = '0;
      nextAddr = '0;
      progLen  = 0;
      cycles   = 0;
      for (int i = 0; i < 256; i++) begin
         vec[i] = '0;
         mem[i] = {8'h00, 8'(i)};   // NOP carrying its own address
      end
      $readmemh("sim/cpuCore_vectors.txt", vec);
      for (int i = 0; i < 256; i += 4) begin
         if (vec[i] == 16'h1) begin
            mem[progLen] = vec[i+1];
            progLen++;
         end else if (vec[i] == 16'h2) begin
            want.addr  = vec[i+1][2:0];
            want.data  = vec[i+2];
            want.flags = opcodes::flags_t'(vec[i+3][3:0]);
            expQ.push_back(want);
         end
      end
      limit = progLen * 40 + 100;
      repeat (4) begin
         @(posedge Clock);
         #1;
         checkPads(Pads, idlePads);
         if (WbValid) begin
            $display("WbValid pulsed while reset was held");
            abortRun();
         end
      end
      nReset = 1'b1;
      // An ALE at address A means word A-4 has already left execute
      while (expQ.size() != 0 || nextAddr < progLen + 5) @(posedge Clock);
      $display("sim passed");
      $finish;
   end

endmodule

// File: sim/cpuCore_asserts.sv
`timescale 1ns/1ps

module cpuCore_asserts (
   input logic                 Clock,
   input logic                 nReset,
   input logic                 fetchReq,
   input logic                 fetchAck,
   input logic                 decReq,
   input logic                 decAck,
   input stageTypes::busPads_t Pads
);

   // Req may only fall once Ack has risen
   fetchReqHold : assert property (@(posedge Clock) disable iff (!nReset)
      fetchReq && !fetchAck |=> fetchReq)
      else $error("fetchQ dropped Req before Ack");

   decReqHold : assert property (@(posedge Clock) disable iff (!nReset)
      decReq && !decAck |=> decReq)
      else $error("decodeQ dropped Req before Ack");

   aleInCycle : assert property (@(posedge Clock) disable iff (!nReset)
      Pads.ALE |-> !Pads.nME)
      else $error("ALE outside a memory cycle");

   busTurn : assert property (@(posedge Clock) disable iff (!nReset)
      !Pads.nOE |-> !Pads.SysBusOe)   // Memory owns the bus
      else $error("Core drives the bus while memory output is enabled");

endmodule

bind cpuCore cpuCore_asserts checks (
   .Clock(Clock), .nReset(nReset), .fetchReq(fetchReq), .fetchAck(fetchAck),
   .decReq(decReq), .decAck(decAck), .Pads(Pads)
);

// File: src/cpuCore.sv
`timescale 1ns/1ps

module cpuCore #(
   parameter int AddrWidth = 8
) (
   input  logic                   Clock,
   input  logic                   nReset,
   input  logic                   Rdy,
   input  logic [15:0]            SysBusIn,
   output stageTypes::busPads_t   Pads,
   output logic                   WbValid,
   output stageTypes::writeBack_t Wb
);

   logic                   fetchLoad;
   logic                   fetchFull;
   logic                   fetchReq;
   logic                   fetchAck;
   stageTypes::fetchWord_t fetchIn;
   stageTypes::fetchWord_t fetchOut;
   logic                   decLoad;
   logic                   decFull;
   logic                   decReq;
   logic                   decAck;
   stageTypes::decoded_t   decIn;
   stageTypes::decoded_t   decOut;

   busFetch #(.AddrWidth(AddrWidth)) fetch (
      .Clock(Clock), .nReset(nReset), .Rdy(Rdy), .SysBusIn(SysBusIn), .Pads(Pads),
      .Full(fetchFull), .Load(fetchLoad), .Word(fetchIn)
   );

   handoff #(.Payload(stageTypes::fetchWord_t)) fetchQ (
      .Clock(Clock), .nReset(nReset), .Load(fetchLoad), .Data(fetchIn),
      .Full(fetchFull), .Req(fetchReq), .Ack(fetchAck), .Out(fetchOut)
   );

   control decode (
      .Clock(Clock), .nReset(nReset), .InReq(fetchReq), .InAck(fetchAck), .In(fetchOut),
      .Full(decFull), .Load(decLoad), .Decoded(decIn)
   );

   handoff #(.Payload(stageTypes::decoded_t)) decodeQ (
      .Clock(Clock), .nReset(nReset), .Load(decLoad), .Data(decIn),
      .Full(decFull), .Req(decReq), .Ack(decAck), .Out(decOut)
   );

   execute exec (
      .Clock(Clock), .nReset(nReset), .InReq(decReq), .InAck(decAck), .In(decOut),
      .WbValid(WbValid), .Wb(Wb)
   );

endmodule

// File: src/execute.sv
`timescale 1ns/1ps

module execute (
   input  logic                   Clock,
   input  logic                   nReset,
   input  logic                   InReq,
   output logic                   InAck,
   input  stageTypes::decoded_t   In,
   output logic                   WbValid,
   output stageTypes::writeBack_t Wb
);

   localparam int W = opcodes::instrWidth;

   logic [W-1:0]         regs [8];
   opcodes::flags_t      flags;
   opcodes::flags_t      newFlags;
   stageTypes::decoded_t cur;
   logic                 retire;   // Cycle after capture
   logic                 accept;
   logic [W-1:0]         op1;
   logic [W-1:0]         op2;
   logic [W:0]           sum;      // Carry or borrow in the top bit

   assign accept = InReq && !InAck && !retire;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         InAck  <= 1'b0;
         retire <= 1'b0;
      end else begin
         retire <= accept;
         if (accept) InAck <= 1'b1;
         else if (InAck && !InReq) InAck <= 1'b0;
      end
   end

   always_ff @(posedge Clock) begin
      if (accept) cur <= In;
   end

   assign op1 = regs[cur.rd];
   assign op2 = cur.Op2Sel ? W'(cur.imm) : regs[cur.rs];

   always_comb begin
      sum      = {1'b0, op1};
      case (cur.aluFn)
         opcodes::FnADD : sum = {1'b0, op1} + {1'b0, op2};
         opcodes::FnADC : sum = {1'b0, op1} + {1'b0, op2} + (W+1)'(flags.C);
         opcodes::FnSUB : sum = {1'b0, op1} - {1'b0, op2};
         opcodes::FnAND : sum = {1'b0, op1 & op2};
         opcodes::FnXOR : sum = {1'b0, op1 ^ op2};
         default        : ;
      endcase
      newFlags.Z = (sum[W-1:0] == '0);
      newFlags.N = sum[W-1];
      case (cur.aluFn)
         opcodes::FnADD, opcodes::FnADC : begin
            newFlags.C = sum[W];
            newFlags.V = (op1[W-1] == op2[W-1]) && (sum[W-1] != op1[W-1]);
         end
         opcodes::FnSUB : begin
            newFlags.C = !sum[W];   // Set when no borrow
            newFlags.V = (op1[W-1] != op2[W-1]) && (sum[W-1] != op1[W-1]);
         end
         default : begin
            newFlags.C = 1'b0;
            newFlags.V = 1'b0;
         end
      endcase
   end

   assign WbValid    = retire && cur.WbEn;
   assign Wb.addr    = cur.rd;
   assign Wb.data    = sum[W-1:0];
   assign Wb.flags   = newFlags;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         flags <= '0;
         for (int i = 0; i < 8; i++) regs[i] <= '0;
      end else if (WbValid) begin
         flags         <= newFlags;
         regs[cur.rd]  <= sum[W-1:0];
      end
   end

endmodule

// File: src/control.sv
`timescale 1ns/1ps

module control (
   input  logic                   Clock,
   input  logic                   nReset,
   input  logic                   InReq,
   output logic                   InAck,
   input  stageTypes::fetchWord_t In,
   input  logic                   Full,
   output logic                   Load,
   output stageTypes::decoded_t   Decoded
);

   opcodes::instr_t word;
   logic            pending;   // Decoded word not yet in decodeQ
   logic            accept;

   assign accept = InReq && !InAck && !pending;
   assign Load   = pending && !Full;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         InAck   <= 1'b0;
         pending <= 1'b0;
      end else begin
         if (accept) begin
            InAck   <= 1'b1;
            pending <= 1'b1;
         end else if (InAck && !InReq) begin
            InAck <= 1'b0;   // Four-phase return to zero
         end
         if (Load) pending <= 1'b0;
      end
   end

   always_ff @(posedge Clock) begin
      if (accept) word <= opcodes::instr_t'(In.instr);
   end

   always_comb begin
      Decoded.rd     = word.rd;
      Decoded.rs     = word.rs;
      Decoded.imm    = word.imm;
      Decoded.aluFn  = opcodes::FnNOP;
      Decoded.Op2Sel = 1'b0;
      Decoded.WbEn   = 1'b1;
      case (word.op)
         opcodes::ADD  : Decoded.aluFn = opcodes::FnADD;
         opcodes::ADDI : begin
            Decoded.aluFn  = opcodes::FnADD;
            Decoded.Op2Sel = 1'b1;
         end
         opcodes::ADC  : Decoded.aluFn = opcodes::FnADC;
         opcodes::ADCI : begin
            Decoded.aluFn  = opcodes::FnADC;
            Decoded.Op2Sel = 1'b1;
         end
         opcodes::SUB  : Decoded.aluFn = opcodes::FnSUB;
         opcodes::AND  : Decoded.aluFn = opcodes::FnAND;
         opcodes::XOR  : Decoded.aluFn = opcodes::FnXOR;
         default       : Decoded.WbEn  = 1'b0;   // NOP and unused codes
      endcase
   end

endmodule

// File: src/busFetch.sv
`timescale 1ns/1ps

module busFetch #(
   parameter int AddrWidth = 8
) (
   input  logic                  Clock,
   input  logic                  nReset,
   input  logic                  Rdy,
   input  logic [15:0]           SysBusIn,
   output stageTypes::busPads_t  Pads,
   input  logic                  Full,
   output logic                  Load,
   output stageTypes::fetchWord_t Word
);

   typedef enum logic [2:0] {
      idle,
      latch1,
      latch2,
      latch3,
      latch4,
      irGet
   } fetchSub_t;

   fetchSub_t            fetchSub;
   logic [AddrWidth-1:0] pc;
   logic [15:0]          wordReg;
   logic                 held;     // Fetched word waiting for fetchQ
   logic                 ENB;      // Input pad enable
   logic [15:0]          busIn;

   assign ENB   = (fetchSub == latch3) || (fetchSub == latch4) || (fetchSub == irGet);
   assign busIn = ENB ? SysBusIn : '0;

   // Hand the word over from idle once fetchQ has room
   assign Load = (fetchSub == idle) && held && !Full;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         fetchSub <= idle;
         pc       <= '0;
         held     <= 1'b0;
      end else begin
         case (fetchSub)
            idle   : if (!held || !Full) fetchSub <= latch1;
            latch1 : fetchSub <= latch2;
            latch2 : fetchSub <= latch3;
            latch3 : fetchSub <= latch4;
            latch4 : fetchSub <= irGet;
            irGet  : if (Rdy) fetchSub <= idle;   // Memory wait
            default: fetchSub <= idle;
         endcase
         if (fetchSub == irGet && Rdy) held <= 1'b1;
         if (Load) begin
            held <= 1'b0;
            pc   <= pc + 1'b1;
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (fetchSub == irGet && Rdy) wordReg <= busIn;
   end

   assign Word.instr = wordReg;
   assign Word.addr  = 16'(pc);

   always_comb begin
      Pads.SysBusOut = '0;
      Pads.SysBusOe  = 1'b0;
      Pads.ALE       = 1'b0;
      Pads.nME       = 1'b1;
      Pads.nOE       = 1'b1;
      case (fetchSub)
         latch1 : begin
            Pads.nME       = 1'b0;
            Pads.ALE       = 1'b1;   // Address latch
            Pads.SysBusOe  = 1'b1;
            Pads.SysBusOut = 16'(pc);
         end
         latch2 : begin
            Pads.nME       = 1'b0;
            Pads.SysBusOe  = 1'b1;   // Address hold
            Pads.SysBusOut = 16'(pc);
         end
         latch3, latch4, irGet : begin
            Pads.nME = 1'b0;
            Pads.nOE = 1'b0;         // Memory drives the bus
         end
         default : ;
      endcase
   end

endmodule

// File: src/handoff.sv
`timescale 1ns/1ps

module handoff #(
   parameter type Payload = logic
) (
   input  logic   Clock,
   input  logic   nReset,
   input  logic   Load,
   input  Payload Data,
   output logic   Full,
   output logic   Req,
   input  logic   Ack,
   output Payload Out
);

   typedef enum logic [1:0] {
      empty,
      offered,    // Req high until Ack rises
      draining    // Req low until Ack falls
   } phase_t;

   phase_t phase;
   Payload held;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         phase <= empty;
      end else begin
         case (phase)
            empty    : if (Load) phase <= offered;
            offered  : if (Ack) phase <= draining;
            draining : if (!Ack) phase <= empty;
            default  : phase <= empty;
         endcase
      end
   end

   always_ff @(posedge Clock) begin
      if (Load && phase == empty) held <= Data;
   end

   assign Full = (phase != empty);   // Back-pressure to the producer
   assign Req  = (phase == offered);
   assign Out  = held;

endmodule

// File: src/stageTypes.sv
package stageTypes;

   // Pad side of the multiplexed system bus
   typedef struct packed {
      logic [opcodes::instrWidth-1:0] SysBusOut;
      logic                           SysBusOe;   // Core drives the bus
      logic                           ALE;
      logic                           nME;
      logic                           nOE;
   } busPads_t;

   typedef struct packed {
      logic [opcodes::instrWidth-1:0] instr;
      logic [opcodes::instrWidth-1:0] addr;   // Fetch address of the word
   } fetchWord_t;

   typedef struct packed {
      opcodes::aluFunction_t aluFn;
      logic [2:0]            rd;
      logic [2:0]            rs;
      logic [3:0]            imm;
      logic                  Op2Sel;   // 1 selects the immediate
      logic                  WbEn;
   } decoded_t;

   typedef struct packed {
      logic [2:0]                     addr;
      logic [opcodes::instrWidth-1:0] data;
      opcodes::flags_t                flags;
   } writeBack_t;

endpackage

// File: src/opcodes.sv
package opcodes;

   localparam int instrWidth = 16;   // Instruction and data word width

   // Major opcode in the top six bits of the word
   typedef enum logic [5:0] {
      NOP  = 6'h00,
      ADD  = 6'h01,
      ADDI = 6'h02,
      ADC  = 6'h03,
      ADCI = 6'h04,
      SUB  = 6'h05,
      AND  = 6'h06,
      XOR  = 6'h07
   } opcode_t;

   typedef enum logic [2:0] {
      FnNOP = 3'd0,
      FnADD = 3'd1,
      FnADC = 3'd2,   // Add with stored carry
      FnSUB = 3'd3,
      FnAND = 3'd4,
      FnXOR = 3'd5
   } aluFunction_t;

   // Word layout from the MSB down
   typedef struct packed {
      opcode_t    op;
      logic [2:0] rd;    // Destination and first operand
      logic [2:0] rs;    // Second operand register
      logic [3:0] imm;   // Zero extended for immediate forms
   } instr_t;

   typedef struct packed {
      logic Z;
      logic N;
      logic C;   // Carry out, or no borrow on SUB
      logic V;
   } flags_t;

endpackage
